// ==== rtl/armConsts.svh ====
`ifndef ARM_CONSTS_SVH
`define ARM_CONSTS_SVH

// datapath and address width
`define ARM_XLEN 32

// register file size and special registers
`define ARM_NREGS 16
`define ARM_PC_REG 15
`define ARM_LR_REG 14

// shift amount field of the register operand
`define ARM_SHIFT_W 5

// first fetch address
`define ARM_RESET_PC 32'h0000_0000

`endif

// ==== rtl/armPkg.sv ====
`include "armConsts.svh"

package armPkg;

    typedef logic [`ARM_XLEN-1:0] word_t;
    typedef logic [$clog2(`ARM_NREGS)-1:0] regIdx_t;

    // the never code 1111 doubles as the NOP
    typedef enum logic [3:0] {
        COND_EQ = 4'b0000,
        COND_NE = 4'b0001,
        COND_GE = 4'b1010,
        COND_LT = 4'b1011,
        COND_AL = 4'b1110,
        COND_NV = 4'b1111
    } condCode_e;

    typedef enum logic [3:0] {
        DP_AND = 4'b0000,
        DP_SUB = 4'b0010,
        DP_ADD = 4'b0100,
        DP_CMP = 4'b1010,
        DP_ORR = 4'b1100,
        DP_MOV = 4'b1101
    } dpOpcode_e;

    typedef enum logic [2:0] {
        ALU_ADD,
        ALU_SUB,
        ALU_AND,
        ALU_ORR,
        ALU_PASSB
    } aluOp_e;

    typedef struct packed {
        logic n;
        logic z;
        logic c;
        logic v;
    } flags_t;

    typedef struct packed {
        condCode_e cond;
        aluOp_e aluOp;
        logic setFlags;
        logic useImm;
        logic isBranch;
        logic isLink;
        logic regWrite;
        logic memRead;
        logic memWrite;
        regIdx_t rd;
        logic [`ARM_SHIFT_W-1:0] shamt;
        word_t opA;
        word_t opB;
        word_t imm;
        word_t pcD;
    } decoded_t;

    typedef struct packed {
        logic regWrite;
        logic memRead;
        logic memWrite;
        logic memToReg;
        regIdx_t rd;
        word_t aluResult;
        word_t storeData;
    } memCtrl_t;

    typedef struct packed {
        logic we;
        regIdx_t rd;
        word_t result;
    } wbCtrl_t;

endpackage

// ==== rtl/registerFile.sv ====
`include "armConsts.svh"

module registerFile (
    input  logic clk,
    input  logic reset,
    input  armPkg::regIdx_t i_rdIdxA,
    input  armPkg::regIdx_t i_rdIdxB,
    input  armPkg::wbCtrl_t i_wb,
    input  logic i_branchTaken,
    input  armPkg::word_t i_branchTarget,
    output armPkg::word_t o_rdDataA,
    output armPkg::word_t o_rdDataB,
    output armPkg::word_t o_pc
);
    import armPkg::*;

    word_t regs [`ARM_NREGS];

    always_ff @(posedge clk or posedge reset) begin
        if (reset) begin
            for (int i = 0; i < `ARM_NREGS; i++) begin
                regs[i] <= '0;
            end
            regs[`ARM_PC_REG] <= `ARM_RESET_PC;
        end else begin
            // R15 belongs to the fetch logic only
            if (i_wb.we && i_wb.rd != regIdx_t'(`ARM_PC_REG)) begin
                regs[i_wb.rd] <= i_wb.result;
            end
            regs[`ARM_PC_REG] <= i_branchTaken ? i_branchTarget : regs[`ARM_PC_REG] + 32'd4;
        end
    end

    assign o_rdDataA = regs[i_rdIdxA];
    assign o_rdDataB = regs[i_rdIdxB];
    assign o_pc = regs[`ARM_PC_REG];

endmodule

// ==== rtl/decodeStage.sv ====
`include "armConsts.svh"

module decodeStage (
    input  logic clk,
    input  logic reset,
    input  armPkg::word_t i_inst,
    input  armPkg::word_t i_rdDataA,
    input  armPkg::word_t i_rdDataB,
    output armPkg::regIdx_t o_rdIdxA,
    output armPkg::regIdx_t o_rdIdxB,
    output armPkg::decoded_t o_decoded
);
    import armPkg::*;

    // never-condition instruction
    localparam word_t NopInst = 32'hF000_0000;

    word_t instD;
    logic isDataProc;
    logic isMemOp;
    logic isBranchOp;
    logic isLoad;

    // IF/ID register
    always_ff @(posedge clk or posedge reset) begin
        if (reset) begin
            instD <= NopInst;
        end else begin
            instD <= i_inst;
        end
    end

    assign isDataProc = instD[27:26] == 2'b00;
    assign isMemOp = instD[27:26] == 2'b01;
    assign isBranchOp = instD[27:25] == 3'b101;
    assign isLoad = instD[20];

    // stores read Rd as the data source
    assign o_rdIdxA = isBranchOp ? regIdx_t'(`ARM_PC_REG) : instD[19:16];
    assign o_rdIdxB = (isMemOp && !isLoad) ? instD[15:12] : instD[3:0];

    always_comb begin
        o_decoded = '0;
        o_decoded.cond = condCode_e'(instD[31:28]);
        o_decoded.aluOp = ALU_ADD;
        o_decoded.rd = instD[15:12];
        o_decoded.shamt = instD[11:7];
        o_decoded.opA = i_rdDataA;
        o_decoded.opB = i_rdDataB;
        if (isBranchOp) begin
            o_decoded.useImm = 1'b1;
            o_decoded.isBranch = 1'b1;
            o_decoded.isLink = instD[24];
            o_decoded.regWrite = instD[24];
            o_decoded.rd = regIdx_t'(`ARM_LR_REG);
            o_decoded.imm = {{6{instD[23]}}, instD[23:0], 2'b00};
            // port A reads R15 for branches
            o_decoded.pcD = i_rdDataA;
        end else if (isMemOp) begin
            o_decoded.useImm = 1'b1;
            o_decoded.memRead = isLoad;
            o_decoded.memWrite = !isLoad;
            o_decoded.regWrite = isLoad;
            o_decoded.imm = {20'b0, instD[11:0]};
        end else if (isDataProc) begin
            o_decoded.useImm = instD[25];
            o_decoded.setFlags = instD[20];
            o_decoded.regWrite = 1'b1;
            o_decoded.imm = {{24{instD[7]}}, instD[7:0]};
            case (dpOpcode_e'(instD[24:21]))
                DP_AND: o_decoded.aluOp = ALU_AND;
                DP_SUB: o_decoded.aluOp = ALU_SUB;
                DP_ADD: o_decoded.aluOp = ALU_ADD;
                DP_ORR: o_decoded.aluOp = ALU_ORR;
                DP_MOV: o_decoded.aluOp = ALU_PASSB;
                DP_CMP: begin
                    o_decoded.aluOp = ALU_SUB;
                    o_decoded.regWrite = 1'b0;
                end
                default: begin
                    o_decoded.regWrite = 1'b0;
                    o_decoded.setFlags = 1'b0;
                end
            endcase
        end
    end

endmodule

// ==== rtl/alu.sv ====
module alu (
    input  armPkg::aluOp_e i_op,
    input  armPkg::word_t i_a,
    input  armPkg::word_t i_b,
    output armPkg::word_t o_result,
    output armPkg::flags_t o_flags
);
    import armPkg::*;

    logic [32:0] sum;

    always_comb begin
        sum = '0;
        o_flags.c = 1'b0;
        o_flags.v = 1'b0;
        case (i_op)
            ALU_ADD: begin
                sum = {1'b0, i_a} + {1'b0, i_b};
                o_result = sum[31:0];
                o_flags.c = sum[32];
                o_flags.v = (i_a[31] == i_b[31]) && (o_result[31] != i_a[31]);
            end
            ALU_SUB: begin
                // carry set means no borrow
                sum = {1'b0, i_a} + {1'b0, ~i_b} + 33'd1;
                o_result = sum[31:0];
                o_flags.c = sum[32];
                o_flags.v = (i_a[31] != i_b[31]) && (o_result[31] != i_a[31]);
            end
            ALU_AND: o_result = i_a & i_b;
            ALU_ORR: o_result = i_a | i_b;
            default: o_result = i_b;
        endcase
        o_flags.n = o_result[31];
        o_flags.z = o_result == '0;
    end

endmodule

// ==== rtl/conditionUnit.sv ====
module conditionUnit (
    input  logic clk,
    input  logic reset,
    input  armPkg::condCode_e i_cond,
    input  logic i_setFlags,
    input  armPkg::flags_t i_aluFlags,
    output logic o_execute
);
    import armPkg::*;

    flags_t flagReg;

    always_comb begin
        case (i_cond)
            COND_EQ: o_execute = flagReg.z;
            COND_NE: o_execute = !flagReg.z;
            COND_GE: o_execute = flagReg.n == flagReg.v;
            COND_LT: o_execute = flagReg.n != flagReg.v;
            COND_AL: o_execute = 1'b1;
            // NV and unsupported codes
            default: o_execute = 1'b0;
        endcase
    end

    // next instruction in E sees these
    always_ff @(posedge clk or posedge reset) begin
        if (reset) begin
            flagReg <= '0;
        end else if (o_execute && i_setFlags) begin
            flagReg <= i_aluFlags;
        end
    end

endmodule

// ==== rtl/executeStage.sv ====
module executeStage (
    input  logic clk,
    input  logic reset,
    input  armPkg::decoded_t i_decoded,
    output armPkg::memCtrl_t o_mem,
    output logic o_branchTaken,
    output armPkg::word_t o_branchTarget
);
    import armPkg::*;

    decoded_t idEx;
    word_t shiftedB;
    word_t aluB;
    word_t aluResult;
    flags_t aluFlags;
    logic execute;

    // ID/EX register
    always_ff @(posedge clk or posedge reset) begin
        if (reset) begin
            idEx <= '0;
        end else begin
            idEx <= i_decoded;
        end
    end

    assign shiftedB = idEx.opB << idEx.shamt;
    assign aluB = idEx.useImm ? idEx.imm : shiftedB;

    // branches read R15 on port A, so opA is the D-stage PC
    alu uAlu (
        .i_op(idEx.aluOp),
        .i_a(idEx.opA),
        .i_b(aluB),
        .o_result(aluResult),
        .o_flags(aluFlags)
    );

    conditionUnit uCond (
        .clk(clk),
        .reset(reset),
        .i_cond(idEx.cond),
        .i_setFlags(idEx.setFlags),
        .i_aluFlags(aluFlags),
        .o_execute(execute)
    );

    assign o_branchTaken = idEx.isBranch && execute;
    assign o_branchTarget = aluResult;

    // EX/MEM register squashed by a failed condition
    always_ff @(posedge clk or posedge reset) begin
        if (reset) begin
            o_mem <= '0;
        end else begin
            o_mem.regWrite <= idEx.regWrite && execute;
            o_mem.memRead <= idEx.memRead && execute;
            o_mem.memWrite <= idEx.memWrite && execute;
            o_mem.memToReg <= idEx.memRead;
            o_mem.rd <= idEx.rd;
            // link is the BL address plus 8
            o_mem.aluResult <= idEx.isLink ? idEx.pcD + 32'd4 : aluResult;
            o_mem.storeData <= idEx.opB;
        end
    end

endmodule

// ==== rtl/writebackStage.sv ====
module writebackStage (
    input  logic clk,
    input  logic reset,
    input  armPkg::memCtrl_t i_mem,
    input  armPkg::word_t i_readData,
    output armPkg::wbCtrl_t o_wb
);
    import armPkg::*;

    memCtrl_t memWb;

    // MEM/WB register
    always_ff @(posedge clk or posedge reset) begin
        if (reset) begin
            memWb <= '0;
        end else begin
            memWb <= i_mem;
        end
    end

    // load data arrives the cycle after the strobe
    always_comb begin
        o_wb.we = memWb.regWrite;
        o_wb.rd = memWb.rd;
        o_wb.result = memWb.memToReg ? i_readData : memWb.aluResult;
    end

endmodule

// ==== rtl/armPipeline.sv ====
module armPipeline (
    input  logic clk,
    input  logic reset,
    input  armPkg::word_t i_inst,
    input  armPkg::word_t i_readData,
    output armPkg::word_t o_pc,
    output armPkg::word_t o_memAddr,
    output logic o_memWrite,
    output logic o_memRead,
    output armPkg::word_t o_writeData
);
    import armPkg::*;

    regIdx_t rdIdxA;
    regIdx_t rdIdxB;
    word_t rdDataA;
    word_t rdDataB;
    word_t branchTarget;
    logic branchTaken;
    decoded_t decoded;
    memCtrl_t memStage;
    wbCtrl_t wbBus;

    registerFile uRegFile (
        .clk(clk),
        .reset(reset),
        .i_rdIdxA(rdIdxA),
        .i_rdIdxB(rdIdxB),
        .i_wb(wbBus),
        .i_branchTaken(branchTaken),
        .i_branchTarget(branchTarget),
        .o_rdDataA(rdDataA),
        .o_rdDataB(rdDataB),
        .o_pc(o_pc)
    );

    decodeStage uDecode (
        .clk(clk),
        .reset(reset),
        .i_inst(i_inst),
        .i_rdDataA(rdDataA),
        .i_rdDataB(rdDataB),
        .o_rdIdxA(rdIdxA),
        .o_rdIdxB(rdIdxB),
        .o_decoded(decoded)
    );

    executeStage uExecute (
        .clk(clk),
        .reset(reset),
        .i_decoded(decoded),
        .o_mem(memStage),
        .o_branchTaken(branchTaken),
        .o_branchTarget(branchTarget)
    );

    writebackStage uWriteback (
        .clk(clk),
        .reset(reset),
        .i_mem(memStage),
        .i_readData(i_readData),
        .o_wb(wbBus)
    );

    // data memory port from the M stage
    assign o_memAddr = memStage.aluResult;
    assign o_memWrite = memStage.memWrite;
    assign o_memRead = memStage.memRead;
    assign o_writeData = memStage.storeData;

endmodule

// ==== bench/armPipelineTb.sv ====
module armPipelineTb;
    timeunit 1ns;
    timeprecision 1ps;
    import armPkg::*;

    localparam word_t Nop = 32'hF000_0000;
    localparam word_t SentinelAddr = 32'h0000_00FC;

    logic clk;
    logic reset;
    word_t inst;
    word_t readData;
    word_t pc;
    word_t memAddr;
    word_t writeData;
    logic memWrite;
    logic memRead;

    word_t imem [256];
    word_t dmem [256];
    word_t prog [$];
    word_t storeAddr [$];
    word_t storeData [$];

    armPipeline UUT (
        .clk(clk),
        .reset(reset),
        .i_inst(inst),
        .i_readData(readData),
        .o_pc(pc),
        .o_memAddr(memAddr),
        .o_memWrite(memWrite),
        .o_memRead(memRead),
        .o_writeData(writeData)
    );

    initial begin
        clk = 1'b0;
        forever #2 clk = ~clk;
    end

    // asynchronous instruction ROM
    assign inst = imem[pc[9:2]];

    // data memory answers a read on the next cycle
    always @(posedge clk) begin
        if (memWrite) begin
            dmem[memAddr[9:2]] <= writeData;
            storeAddr.push_back(memAddr);
            storeData.push_back(writeData);
        end
        if (memRead) begin
            readData <= dmem[memAddr[9:2]];
        end
    end

    function automatic word_t sx8(logic [7:0] v);
        return {{24{v[7]}}, v};
    endfunction

    function automatic word_t dpImm(condCode_e c, dpOpcode_e op, logic s, logic [3:0] rn,
                                    logic [3:0] rd, logic [7:0] imm);
        return {c, 3'b001, op, s, rn, rd, 4'b0000, imm};
    endfunction

    function automatic word_t dpReg(dpOpcode_e op, logic [3:0] rn, logic [3:0] rd,
                                    logic [4:0] sh, logic [3:0] rm);
        return {COND_AL, 3'b000, op, 1'b0, rn, rd, sh, 3'b000, rm};
    endfunction

    function automatic word_t memOp(logic load, logic [3:0] rn, logic [3:0] rd,
                                    logic [11:0] off);
        return {COND_AL, 2'b01, 5'b01100, load, rn, rd, off};
    endfunction

    function automatic word_t branchOp(logic link, logic [23:0] off);
        return {COND_AL, 3'b101, link, off};
    endfunction

    task automatic stopRun();
        $display("Some tests failed");
        $fatal(1, "simulation stopped");
    endtask

    task automatic checkEq(word_t got, word_t exp, string what);
        if (got !== exp) begin
            $display("CHECK FAILED at %0t ns: %s got %h expected %h", $time, what, got, exp);
            stopRun();
        end
    endtask

    task automatic emit(word_t w);
        prog.push_back(w);
    endtask

    task automatic emitNops(int n);
        repeat (n) prog.push_back(Nop);
    endtask

    task automatic loadProgram();
        for (int i = 0; i < 256; i++) begin
            imem[i] = Nop;
        end
        foreach (prog[i]) begin
            imem[i] = prog[i];
        end
        prog.delete();
    endtask

    task automatic applyReset();
        @(posedge clk);
        reset <= 1'b1;
        repeat (3) begin
            @(posedge clk);
            checkEq(memWrite, 0, "memwrite during reset");
            checkEq(memRead, 0, "memread during reset");
        end
        reset <= 1'b0;
        storeAddr.delete();
        storeData.delete();
    endtask

    // program ends with a store to the sentinel address
    task automatic runProgram();
        bit found;
        found = 0;
        emit(memOp(1'b0, 4'd0, 4'd0, SentinelAddr[11:0]));
        loadProgram();
        applyReset();
        for (int i = 0; i < 400; i++) begin
            @(posedge clk);
            if (memWrite && memAddr == SentinelAddr) begin
                found = 1;
                break;
            end
        end
        if (!found) begin
            $display("timeout: the sentinel store never appeared");
            stopRun();
        end
        @(posedge clk);
        checkEq(storeAddr.pop_back(), SentinelAddr, "last store is the sentinel");
        void'(storeData.pop_back());
    endtask

    task automatic expectStore(word_t addr, word_t data, string what);
        if (storeAddr.size() == 0) begin
            $display("missing store for %s", what);
            stopRun();
        end
        checkEq(storeAddr.pop_front(), addr, {what, " address"});
        checkEq(storeData.pop_front(), data, {what, " data"});
    endtask

    task automatic testResetAndFetch();
        word_t expPc;
        loadProgram();
        applyReset();
        expPc = 32'h0;
        repeat (8) begin
            @(posedge clk);
            checkEq(pc, expPc, "pc after reset");
            checkEq(memWrite, 0, "memwrite idle");
            checkEq(memRead, 0, "memread idle");
            expPc += 4;
        end
    endtask

    task automatic testDataOps();
        logic [7:0] a;
        logic [7:0] b;
        logic [4:0] sh;
        word_t shifted;
        a = 8'($urandom());
        b = 8'($urandom());
        sh = 5'($urandom());
        shifted = sx8(b) << sh;
        emit(dpImm(COND_AL, DP_MOV, 1'b0, 4'd0, 4'd1, a));
        emit(dpImm(COND_AL, DP_MOV, 1'b0, 4'd0, 4'd2, b));
        emit(dpImm(COND_AL, DP_MOV, 1'b0, 4'd0, 4'd8, 8'h20));
        emitNops(3);
        emit(dpReg(DP_ADD, 4'd1, 4'd3, sh, 4'd2));
        emit(dpImm(COND_AL, DP_SUB, 1'b0, 4'd1, 4'd4, b));
        emit(dpReg(DP_AND, 4'd1, 4'd5, sh, 4'd2));
        emit(dpImm(COND_AL, DP_ORR, 1'b0, 4'd1, 4'd6, b));
        emitNops(3);
        for (int r = 1; r <= 6; r++) begin
            emit(memOp(1'b0, 4'd8, 4'(r), 12'(4 * r)));
        end
        runProgram();
        expectStore(32'h24, sx8(a), "MOV");
        expectStore(32'h28, sx8(b), "MOV second");
        expectStore(32'h2C, sx8(a) + shifted, "ADD shifted");
        expectStore(32'h30, sx8(a) - sx8(b), "SUB imm");
        expectStore(32'h34, sx8(a) & shifted, "AND shifted");
        expectStore(32'h38, sx8(a) | sx8(b), "ORR imm");
        checkEq(storeAddr.size(), 0, "extra stores");
    endtask

    task automatic testLoadUse();
        logic [7:0] a;
        logic [7:0] k;
        a = 8'($urandom());
        k = 8'($urandom());
        emit(dpImm(COND_AL, DP_MOV, 1'b0, 4'd0, 4'd1, a));
        emitNops(3);
        emit(memOp(1'b0, 4'd0, 4'd1, 12'h40));
        emit(memOp(1'b1, 4'd0, 4'd2, 12'h40));
        emitNops(3);
        emit(dpImm(COND_AL, DP_ADD, 1'b0, 4'd2, 4'd3, k));
        emitNops(3);
        emit(memOp(1'b0, 4'd0, 4'd3, 12'h44));
        runProgram();
        expectStore(32'h40, sx8(a), "STR before load");
        expectStore(32'h44, sx8(a) + sx8(k), "ADD on loaded value");
        checkEq(storeAddr.size(), 0, "extra stores");
    endtask

    task automatic testConditions(logic [7:0] a, logic [7:0] b);
        logic signed [31:0] sa;
        logic signed [31:0] sb;
        sa = sx8(a);
        sb = sx8(b);
        emit(dpImm(COND_AL, DP_MOV, 1'b0, 4'd0, 4'd1, a));
        emit(dpImm(COND_AL, DP_MOV, 1'b0, 4'd0, 4'd2, b));
        emitNops(3);
        emit(dpReg(DP_CMP, 4'd1, 4'd0, 5'd0, 4'd2) | 32'h0010_0000);
        emit(dpImm(COND_EQ, DP_ADD, 1'b0, 4'd3, 4'd3, 8'd1));
        emit(dpImm(COND_NE, DP_ADD, 1'b0, 4'd4, 4'd4, 8'd1));
        emit(dpImm(COND_GE, DP_ADD, 1'b0, 4'd5, 4'd5, 8'd1));
        emit(dpImm(COND_LT, DP_ADD, 1'b0, 4'd6, 4'd6, 8'd1));
        // never executes
        emit(dpImm(COND_NV, DP_ADD, 1'b0, 4'd0, 4'd7, 8'd5));
        emitNops(3);
        for (int r = 3; r <= 7; r++) begin
            emit(memOp(1'b0, 4'd0, 4'(r), 12'(32'h50 + 4 * r)));
        end
        runProgram();
        expectStore(32'h5C, word_t'(sa == sb), "ADDEQ");
        expectStore(32'h60, word_t'(sa != sb), "ADDNE");
        expectStore(32'h64, word_t'(sa >= sb), "ADDGE");
        expectStore(32'h68, word_t'(sa < sb), "ADDLT");
        expectStore(32'h6C, 32'h0, "NV");
        checkEq(storeAddr.size(), 0, "extra stores");
    endtask

    task automatic testBranches();
        // target is the branch address plus 4 plus the scaled offset
        emit(branchOp(1'b0, 24'd4));
        emit(memOp(1'b0, 4'd0, 4'd0, 12'h80));
        emit(memOp(1'b0, 4'd0, 4'd0, 12'h84));
        emit(memOp(1'b0, 4'd0, 4'd0, 12'h88));
        emit(memOp(1'b0, 4'd0, 4'd0, 12'h8C));
        emit(branchOp(1'b1, 24'd3));
        emitNops(2);
        emit(memOp(1'b0, 4'd0, 4'd0, 12'h90));
        emitNops(1);
        emit(memOp(1'b0, 4'd0, 4'd14, 12'h94));
        runProgram();
        expectStore(32'h80, 32'h0, "first delay slot");
        expectStore(32'h84, 32'h0, "second delay slot");
        expectStore(32'h94, 32'h14 + 32'd8, "link register");
        checkEq(storeAddr.size(), 0, "skipped stores");
    endtask

    initial begin
        reset = 1'b1;
        readData = '0;
        void'($urandom(23));
        testResetAndFetch();
        repeat (3) testDataOps();
        repeat (3) testLoadUse();
        testConditions(8'h15, 8'h15);
        testConditions(8'h80, 8'h7F);
        repeat (4) testConditions(8'($urandom()), 8'($urandom()));
        testBranches();
        $display("All tests passed");
        $finish;
    end

endmodule

// ==== project.f ====
+incdir+rtl
rtl/armPkg.sv
rtl/registerFile.sv
rtl/decodeStage.sv
rtl/alu.sv
rtl/conditionUnit.sv
rtl/executeStage.sv
rtl/writebackStage.sv
rtl/armPipeline.sv
bench/armPipelineTb.sv

// ==== Makefile ====
VERILATOR ?= verilator
TOP ?= armPipelineTb
BUILD_DIR ?= build
FILELIST ?= project.f
PASS_MSG ?= All tests passed

.PHONY: all build run lint clean

all: run

build:
	$(VERILATOR) --binary --timing -f $(FILELIST) --top-module $(TOP) -Mdir $(BUILD_DIR)

run: build
	./$(BUILD_DIR)/V$(TOP) | tee /dev/stderr | grep -q "$(PASS_MSG)"

lint:
	$(VERILATOR) --lint-only --timing -f $(FILELIST) --top-module $(TOP)

clean:
	rm -rf $(BUILD_DIR)
